//--- tb.f
hw/mem_types_pkg.sv
hw/lane_ops_pkg.sv
hw/mem_stage_control.sv
hw/lane_load_unit.sv
hw/mem_writeback_merge.sv
hw/data_tim.sv
hw/mem_subsystem_top.sv
sim/tb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_mem_subsystem -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0

//--- sim/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_OPS   = 300;
  localparam int NUM_OPS      = mem_types_pkg::DTIM_WORDS + 64 + RANDOM_OPS;
  localparam int NL           = lane_ops_pkg::NUM_LANES;

  logic clock;
  logic reset;
  logic clear;
  lane_ops_pkg::mem_kind_t [NL-1:0]    lane_kind;
  lane_ops_pkg::lsu_op_t [NL-1:0]      lane_lsu_op;
  mem_types_pkg::addr_t [NL-1:0]       lane_addr;
  mem_types_pkg::word_t [NL-1:0]       lane_sdata;
  logic [NL-1:0]                       lane_wren;
  mem_types_pkg::reg_addr_t [NL-1:0]   lane_waddr;
  mem_types_pkg::word_t [NL-1:0]       lane_wdata;
  logic [NL-1:0]                       lane_cwren;
  mem_types_pkg::csr_addr_t [NL-1:0]   lane_caddr;
  mem_types_pkg::word_t [NL-1:0]       lane_cdata;
  logic [NL-1:0]                       lane_exception;
  mem_types_pkg::cause_t [NL-1:0]      lane_ecause;
  mem_types_pkg::addr_t [NL-1:0]       lane_pc;
  logic                                stall;
  logic [NL-1:0]                       fwd_wren;
  mem_types_pkg::reg_addr_t [NL-1:0]   fwd_waddr;
  mem_types_pkg::word_t [NL-1:0]       fwd_wdata;
  logic                                csr_wren;
  mem_types_pkg::csr_addr_t            csr_waddr;
  mem_types_pkg::word_t                csr_wdata;
  logic                                exc_valid;
  mem_types_pkg::addr_t                exc_pc;
  mem_types_pkg::cause_t               exc_cause;

  // reference model state
  mem_types_pkg::word_t                shadow [mem_types_pkg::DTIM_WORDS];
  logic [NL-1:0]                       exp_wren;
  mem_types_pkg::reg_addr_t [NL-1:0]   exp_waddr;
  mem_types_pkg::word_t [NL-1:0]       exp_wdata;
  logic                                exp_cwren;
  mem_types_pkg::csr_addr_t            exp_caddr;
  mem_types_pkg::word_t                exp_cdata;
  logic                                exp_exc;
  mem_types_pkg::addr_t                exp_pc;
  mem_types_pkg::cause_t               exp_cause;
  logic                                stall_due;
  logic [31:0]                         lcg_state;

  mem_subsystem_top i_mem_subsystem_top (.*);

  always #5 clock = ~clock;

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ========================================
  // reference functions
  // ========================================

  function automatic mem_types_pkg::word_t ref_load(lane_ops_pkg::lsu_op_t op, logic [1:0] a,
                                                     mem_types_pkg::word_t w);
    mem_types_pkg::word_t sh;
    sh = w >> (8 * int'(a));
    case (op)
      lane_ops_pkg::op_lb:  return {{24{sh[7]}}, sh[7:0]};
      lane_ops_pkg::op_lbu: return {24'h0, sh[7:0]};
      lane_ops_pkg::op_lh:  return {{16{sh[15]}}, sh[15:0]};
      lane_ops_pkg::op_lhu: return {16'h0, sh[15:0]};
      default:              return w;
    endcase
  endfunction

  function automatic mem_types_pkg::word_t ref_store(lane_ops_pkg::lsu_op_t op, logic [1:0] a,
                                                      mem_types_pkg::word_t old,
                                                      mem_types_pkg::word_t d);
    mem_types_pkg::word_t r;
    r = old;
    case (op)
      lane_ops_pkg::op_sb: r[8 * int'(a) +: 8] = d[7:0];
      lane_ops_pkg::op_sh: r[8 * int'(a) +: 16] = d[15:0];
      default:             r = d;
    endcase
    return r;
  endfunction

  task automatic report_mismatch(string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_word(string what, mem_types_pkg::word_t got, mem_types_pkg::word_t exp);
    if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_reg(string what, mem_types_pkg::reg_addr_t got,
                           mem_types_pkg::reg_addr_t exp);
    if (got !== exp) report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  task automatic check_csr(string what, mem_types_pkg::csr_addr_t got,
                           mem_types_pkg::csr_addr_t exp);
    if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_cause(string what, mem_types_pkg::cause_t got, mem_types_pkg::cause_t exp);
    if (got !== exp) report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  // ========================================
  // compare and predict, at negedge
  // ========================================

  always @(negedge clock) begin
    int m;
    logic fence0;
    logic [NL-1:0] cw;
    logic [NL-1:0] ex;
    mem_types_pkg::dtim_index_t idx;
    mem_types_pkg::word_t old;
    if (reset) begin
      if (clear) begin
        check_flag("stall during clear", stall, 1'b0);
        exp_wren  = '0;  // flushed pair
        exp_cwren = 1'b0;
        exp_exc   = 1'b0;
        stall_due = 1'b0;
      end else if (stall) begin
        check_flag("stall", stall, stall_due);
        for (int l = 0; l < NL; l++) check_flag("fwd_wren in stall", fwd_wren[l], 1'b0);
        check_flag("csr_wren in stall", csr_wren, 1'b0);
        check_flag("exc_valid in stall", exc_valid, 1'b0);
        stall_due = 1'b0;
      end else begin
        check_flag("stall", stall, stall_due);
        for (int l = 0; l < NL; l++) begin
          check_flag("fwd_wren", fwd_wren[l], exp_wren[l]);
          if (exp_wren[l]) begin
            check_reg("fwd_waddr", fwd_waddr[l], exp_waddr[l]);
            check_word("fwd_wdata", fwd_wdata[l], exp_wdata[l]);
          end
        end
        check_flag("csr_wren", csr_wren, exp_cwren);
        if (exp_cwren) begin
          check_csr("csr_waddr", csr_waddr, exp_caddr);
          check_word("csr_wdata", csr_wdata, exp_cdata);
        end
        check_flag("exc_valid", exc_valid, exp_exc);
        if (exp_exc) begin
          check_word("exc_pc", exc_pc, exp_pc);
          check_cause("exc_cause", exc_cause, exp_cause);
        end
        // the next edge samples the current inputs
        m      = (lane_kind[0] != lane_ops_pkg::kind_none) ? 0 : 1;
        fence0 = (lane_kind[0] == lane_ops_pkg::kind_fence);
        idx    = lane_addr[m][9:2];
        old    = shadow[idx];
        if (lane_kind[m] == lane_ops_pkg::kind_store) begin
          shadow[idx] = ref_store(lane_lsu_op[m], lane_addr[m][1:0], old, lane_sdata[m]);
        end
        stall_due = (lane_kind[m] != lane_ops_pkg::kind_none) &&
                    lane_addr[m][mem_types_pkg::SLOW_BIT];
        for (int l = 0; l < NL; l++) begin
          exp_wren[l]  = lane_wren[l] && !(l == 1 && fence0);
          exp_waddr[l] = lane_waddr[l];
          exp_wdata[l] = (lane_kind[l] == lane_ops_pkg::kind_load) ?
                         ref_load(lane_lsu_op[l], lane_addr[l][1:0], old) : lane_wdata[l];
        end
        cw = {lane_cwren[1] && !fence0, lane_cwren[0]};
        ex = {lane_exception[1] && !fence0, lane_exception[0]};
        exp_cwren = |cw;
        exp_caddr = lane_caddr[cw[0] ? 0 : 1];
        exp_cdata = lane_cdata[cw[0] ? 0 : 1];
        exp_exc   = |ex;
        exp_pc    = lane_pc[ex[0] ? 0 : 1];
        exp_cause = lane_ecause[ex[0] ? 0 : 1];
      end
    end
  end

  // ========================================
  // stimulus
  // ========================================

  task automatic issue(lane_ops_pkg::mem_kind_t k0, lane_ops_pkg::lsu_op_t o0,
                       mem_types_pkg::addr_t a0, lane_ops_pkg::mem_kind_t k1,
                       lane_ops_pkg::lsu_op_t o1, mem_types_pkg::addr_t a1,
                       logic [1:0] cw, logic [1:0] ex);
    @(posedge clock);
    lane_kind[0]   <= k0;
    lane_kind[1]   <= k1;
    lane_lsu_op[0] <= o0;
    lane_lsu_op[1] <= o1;
    lane_addr[0]   <= a0;
    lane_addr[1]   <= a1;
    lane_wren      <= 2'b11;
    lane_cwren     <= cw;
    lane_exception <= ex;
    for (int l = 0; l < NL; l++) begin
      lane_sdata[l]  <= rand32();
      lane_waddr[l]  <= 5'(rand32() >> 20);
      lane_wdata[l]  <= rand32();
      lane_caddr[l]  <= 12'(rand32() >> 16);
      lane_cdata[l]  <= rand32();
      lane_ecause[l] <= 4'(rand32() >> 24);
      lane_pc[l]     <= rand32() & 32'hffff_fffc;
    end
    @(negedge clock);
    while (stall) @(negedge clock);  // held until sampled
  endtask

  task automatic issue_mem(lane_ops_pkg::mem_kind_t k, lane_ops_pkg::lsu_op_t op,
                           mem_types_pkg::addr_t a);
    issue(k, op, a, lane_ops_pkg::kind_none, lane_ops_pkg::op_lw, '0, 2'b00, 2'b00);
  endtask

  function automatic lane_ops_pkg::lsu_op_t pick_op(lane_ops_pkg::mem_kind_t k, logic [31:0] r);
    if (k == lane_ops_pkg::kind_load) return lane_ops_pkg::lsu_op_t'(3'(int'(r[7:4]) % 5));
    if (k == lane_ops_pkg::kind_store) return lane_ops_pkg::lsu_op_t'(3'(5 + int'(r[7:4]) % 3));
    return lane_ops_pkg::op_lw;
  endfunction

  function automatic mem_types_pkg::addr_t rand_addr(lane_ops_pkg::lsu_op_t op, logic [31:0] r);
    logic [1:0] low;
    case (op)
      lane_ops_pkg::op_lb, lane_ops_pkg::op_lbu, lane_ops_pkg::op_sb: low = r[1:0];
      lane_ops_pkg::op_lh, lane_ops_pkg::op_lhu, lane_ops_pkg::op_sh: low = {r[1], 1'b0};
      default: low = 2'b00;
    endcase
    return {21'h0, r[10] & r[11], r[19:12], low};  // one in four goes slow
  endfunction

  initial begin
    watchdog_start: begin
      repeat (RESET_CYCLES + 40 * NUM_OPS) @(posedge clock);
      $display("Watchdog expired: the DUT stopped making progress");
      $display("Errors found");
      $fatal(1);
    end
  end

  initial begin
    logic [31:0] r;
    lane_ops_pkg::mem_kind_t k0;
    lane_ops_pkg::mem_kind_t k1;
    clock = 1'b0;
    reset = 1'b0;
    clear = 1'b0;
    lcg_state = 32'h2c50_58d0;
    stall_due = 1'b0;
    exp_wren = '0;
    exp_cwren = 1'b0;
    exp_exc = 1'b0;
    for (int l = 0; l < NL; l++) begin
      lane_kind[l]   = lane_ops_pkg::kind_none;
      lane_lsu_op[l] = lane_ops_pkg::op_lw;
      lane_addr[l]   = '0;
      lane_sdata[l]  = '0;
      lane_waddr[l]  = '0;
      lane_wdata[l]  = '0;
      lane_caddr[l]  = '0;
      lane_cdata[l]  = '0;
      lane_ecause[l] = '0;
      lane_pc[l]     = '0;
    end
    lane_wren = '0;
    lane_cwren = '0;
    lane_exception = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b1;
    // fill every dtim word so that loads never see unknown data
    for (int i = 0; i < mem_types_pkg::DTIM_WORDS; i++) begin
      issue_mem(lane_ops_pkg::kind_store, lane_ops_pkg::op_sw, 32'(i * 4));
    end
    // store then load, every width
    for (int o = 0; o < 4; o++) begin
      issue_mem(lane_ops_pkg::kind_store, lane_ops_pkg::op_sb, 32'h100 + 32'(o));
      issue_mem(lane_ops_pkg::kind_load, lane_ops_pkg::op_lb, 32'h100 + 32'(o));
      issue_mem(lane_ops_pkg::kind_load, lane_ops_pkg::op_lbu, 32'h100 + 32'(o));
    end
    for (int o = 0; o < 4; o += 2) begin
      issue_mem(lane_ops_pkg::kind_store, lane_ops_pkg::op_sh, 32'h104 + 32'(o));
      issue_mem(lane_ops_pkg::kind_load, lane_ops_pkg::op_lh, 32'h104 + 32'(o));
      issue_mem(lane_ops_pkg::kind_load, lane_ops_pkg::op_lhu, 32'h104 + 32'(o));
    end
    issue_mem(lane_ops_pkg::kind_store, lane_ops_pkg::op_sw, 32'h108);
    issue_mem(lane_ops_pkg::kind_load, lane_ops_pkg::op_lw, 32'h108);
    // slow region
    issue_mem(lane_ops_pkg::kind_store, lane_ops_pkg::op_sw, 32'h40c);
    issue_mem(lane_ops_pkg::kind_load, lane_ops_pkg::op_lw, 32'h40c);
    // lane priority
    issue(lane_ops_pkg::kind_store, lane_ops_pkg::op_sw, 32'h110,
          lane_ops_pkg::kind_store, lane_ops_pkg::op_sw, 32'h114, 2'b11, 2'b11);
    issue_mem(lane_ops_pkg::kind_load, lane_ops_pkg::op_lw, 32'h114);
    issue(lane_ops_pkg::kind_none, lane_ops_pkg::op_lw, '0,
          lane_ops_pkg::kind_none, lane_ops_pkg::op_lw, '0, 2'b10, 2'b10);
    // fence kills lane 1
    issue(lane_ops_pkg::kind_fence, lane_ops_pkg::op_lw, '0,
          lane_ops_pkg::kind_none, lane_ops_pkg::op_lw, '0, 2'b10, 2'b10);
    // clear during a slow stall
    issue_mem(lane_ops_pkg::kind_load, lane_ops_pkg::op_lw, 32'h420);
    @(posedge clock);
    clear          <= 1'b1;
    lane_kind[0]   <= lane_ops_pkg::kind_none;
    lane_kind[1]   <= lane_ops_pkg::kind_none;
    lane_wren      <= '0;
    lane_cwren     <= '0;
    lane_exception <= '0;
    @(posedge clock);
    clear <= 1'b0;
    // random mix
    for (int n = 0; n < RANDOM_OPS; n++) begin
      r  = rand32() >> 8;
      k0 = lane_ops_pkg::mem_kind_t'(r[1:0]);
      if (k0 == lane_ops_pkg::kind_none) begin
        k1 = lane_ops_pkg::mem_kind_t'(r[3:2]);
      end else begin
        k1 = (r[3:2] == 2'b00) ? lane_ops_pkg::kind_store : lane_ops_pkg::kind_none;
      end
      issue(k0, pick_op(k0, r), rand_addr(pick_op(k0, r), rand32() >> 8),
            k1, pick_op(k1, r >> 4), rand_addr(pick_op(k1, r >> 4), rand32() >> 8),
            r[21:20], r[23:22] & r[17:16]);
    end
    issue_mem(lane_ops_pkg::kind_none, lane_ops_pkg::op_lw, '0);
    repeat (4) @(negedge clock);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
  input  wire clock,
  input  wire reset,
  input  wire clear,
  input  wire lane_ops_pkg::mem_kind_t [lane_ops_pkg::NUM_LANES-1:0] lane_kind,
  input  wire lane_ops_pkg::lsu_op_t [lane_ops_pkg::NUM_LANES-1:0] lane_lsu_op,
  input  wire mem_types_pkg::addr_t [lane_ops_pkg::NUM_LANES-1:0] lane_addr,
  input  wire mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] lane_sdata,
  input  wire [lane_ops_pkg::NUM_LANES-1:0] lane_wren,
  input  wire mem_types_pkg::reg_addr_t [lane_ops_pkg::NUM_LANES-1:0] lane_waddr,
  input  wire mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] lane_wdata,
  input  wire [lane_ops_pkg::NUM_LANES-1:0] lane_cwren,
  input  wire mem_types_pkg::csr_addr_t [lane_ops_pkg::NUM_LANES-1:0] lane_caddr,
  input  wire mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] lane_cdata,
  input  wire [lane_ops_pkg::NUM_LANES-1:0] lane_exception,
  input  wire mem_types_pkg::cause_t [lane_ops_pkg::NUM_LANES-1:0] lane_ecause,
  input  wire mem_types_pkg::addr_t [lane_ops_pkg::NUM_LANES-1:0] lane_pc,
  output logic stall,
  output logic [lane_ops_pkg::NUM_LANES-1:0] fwd_wren,
  output mem_types_pkg::reg_addr_t [lane_ops_pkg::NUM_LANES-1:0] fwd_waddr,
  output mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] fwd_wdata,
  output logic csr_wren,
  output mem_types_pkg::csr_addr_t csr_waddr,
  output mem_types_pkg::word_t csr_wdata,
  output logic exc_valid,
  output mem_types_pkg::addr_t exc_pc,
  output mem_types_pkg::cause_t exc_cause
);

  // ======================================
  // dtim bus
  // ======================================

  logic                 mem_valid;
  logic                 mem_fence;
  mem_types_pkg::addr_t mem_addr;
  mem_types_pkg::word_t mem_wdata;
  mem_types_pkg::strb_t mem_wstrb;
  logic                 mem_ready;
  mem_types_pkg::word_t mem_rdata;

  // ======================================
  // stage register and load results
  // ======================================

  lane_ops_pkg::mem_kind_t [lane_ops_pkg::NUM_LANES-1:0]    st_kind;
  lane_ops_pkg::lsu_op_t [lane_ops_pkg::NUM_LANES-1:0]      st_lsu_op;
  mem_types_pkg::addr_t [lane_ops_pkg::NUM_LANES-1:0]       st_addr;
  logic [lane_ops_pkg::NUM_LANES-1:0]                       st_wren;
  mem_types_pkg::reg_addr_t [lane_ops_pkg::NUM_LANES-1:0]   st_waddr;
  mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0]       st_wdata;
  logic [lane_ops_pkg::NUM_LANES-1:0]                       st_cwren;
  mem_types_pkg::csr_addr_t [lane_ops_pkg::NUM_LANES-1:0]   st_caddr;
  mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0]       st_cdata;
  logic [lane_ops_pkg::NUM_LANES-1:0]                       st_exception;
  mem_types_pkg::cause_t [lane_ops_pkg::NUM_LANES-1:0]      st_ecause;
  mem_types_pkg::addr_t [lane_ops_pkg::NUM_LANES-1:0]       st_pc;
  mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0]       wb_data;

  mem_stage_control i_mem_stage_control (.*);

  for (genvar l = 0; l < lane_ops_pkg::NUM_LANES; l++) begin : g_load_unit
    lane_load_unit i_lane_load_unit (
      .st_kind     (st_kind[l]),
      .st_lsu_op   (st_lsu_op[l]),
      .st_addr_low (st_addr[l][1:0]),
      .st_wdata    (st_wdata[l]),
      .rdata       (mem_rdata),  // single port shared by both lanes
      .wb_data     (wb_data[l])
    );
  end

  mem_writeback_merge i_mem_writeback_merge (.*);

  data_tim i_data_tim (.*);

endmodule

`default_nettype wire

//--- hw/data_tim.sv
`timescale 1ns/1ps
`default_nettype none

module data_tim (
  input  wire clock,
  input  wire reset,
  input  wire mem_valid,
  input  wire mem_fence,
  input  wire mem_types_pkg::addr_t mem_addr,
  input  wire mem_types_pkg::word_t mem_wdata,
  input  wire mem_types_pkg::strb_t mem_wstrb,
  output logic mem_ready,
  output mem_types_pkg::word_t mem_rdata
);

  mem_types_pkg::word_t        ram [mem_types_pkg::DTIM_WORDS];
  lane_ops_pkg::dtim_state_t   state;
  mem_types_pkg::dtim_index_t  index;
  logic                        slow;
  logic                        accept;

  assign index     = mem_addr[2 +: $bits(mem_types_pkg::dtim_index_t)];
  assign slow      = mem_addr[mem_types_pkg::SLOW_BIT];
  assign accept    = mem_valid && (state != lane_ops_pkg::dtim_wait);  // held copy ignored
  assign mem_ready = (state == lane_ops_pkg::dtim_respond);

  // ======================================
  // handshake FSM
  // ======================================

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= lane_ops_pkg::dtim_idle;
    end else begin
      case (state)
        lane_ops_pkg::dtim_wait: state <= lane_ops_pkg::dtim_respond;
        default: begin
          if (!accept) begin
            state <= lane_ops_pkg::dtim_idle;
          end else if (slow) begin
            state <= lane_ops_pkg::dtim_wait;
          end else begin
            state <= lane_ops_pkg::dtim_respond;
          end
        end
      endcase
    end
  end

  // ======================================
  // storage, read and write at acceptance
  // ======================================

  always_ff @(posedge clock) begin
    if (accept) begin
      for (int b = 0; b < $bits(mem_types_pkg::strb_t); b++) begin
        if (mem_wstrb[b] && !mem_fence) begin
          ram[index][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
      mem_rdata <= ram[index];  // old word, held through wait
    end
  end

endmodule

`default_nettype wire

//--- hw/mem_writeback_merge.sv
`timescale 1ns/1ps
`default_nettype none

module mem_writeback_merge (
  input  wire stall,
  input  wire mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] wb_data,
  input  wire [lane_ops_pkg::NUM_LANES-1:0] st_wren,
  input  wire mem_types_pkg::reg_addr_t [lane_ops_pkg::NUM_LANES-1:0] st_waddr,
  input  wire [lane_ops_pkg::NUM_LANES-1:0] st_cwren,
  input  wire mem_types_pkg::csr_addr_t [lane_ops_pkg::NUM_LANES-1:0] st_caddr,
  input  wire mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] st_cdata,
  input  wire [lane_ops_pkg::NUM_LANES-1:0] st_exception,
  input  wire mem_types_pkg::cause_t [lane_ops_pkg::NUM_LANES-1:0] st_ecause,
  input  wire mem_types_pkg::addr_t [lane_ops_pkg::NUM_LANES-1:0] st_pc,
  output logic [lane_ops_pkg::NUM_LANES-1:0] fwd_wren,
  output mem_types_pkg::reg_addr_t [lane_ops_pkg::NUM_LANES-1:0] fwd_waddr,
  output mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] fwd_wdata,
  output logic csr_wren,
  output mem_types_pkg::csr_addr_t csr_waddr,
  output mem_types_pkg::word_t csr_wdata,
  output logic exc_valid,
  output mem_types_pkg::addr_t exc_pc,
  output mem_types_pkg::cause_t exc_cause
);

  logic csr_sel;  // lane 1 only when lane 0 is quiet
  logic exc_sel;

  // ======================================
  // register forwarding, one per lane
  // ======================================

  assign fwd_wren  = st_wren & {lane_ops_pkg::NUM_LANES{~stall}};
  assign fwd_waddr = st_waddr;
  assign fwd_wdata = wb_data;

  // ======================================
  // csr write and trap report
  // ======================================

  assign csr_sel   = ~st_cwren[0];
  assign csr_wren  = (|st_cwren) & ~stall;
  assign csr_waddr = st_caddr[csr_sel];
  assign csr_wdata = st_cdata[csr_sel];

  assign exc_sel   = ~st_exception[0];  // oldest lane reports first
  assign exc_valid = (|st_exception) & ~stall;
  assign exc_pc    = st_pc[exc_sel];
  assign exc_cause = st_ecause[exc_sel];

endmodule

`default_nettype wire

//--- hw/lane_load_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lane_load_unit (
  input  wire lane_ops_pkg::mem_kind_t st_kind,
  input  wire lane_ops_pkg::lsu_op_t st_lsu_op,
  input  wire [1:0] st_addr_low,
  input  wire mem_types_pkg::word_t st_wdata,
  input  wire mem_types_pkg::word_t rdata,
  output mem_types_pkg::word_t wb_data
);

  logic [7:0]  byte_data;
  logic [15:0] half_data;

  assign byte_data = rdata[{st_addr_low, 3'b000} +: 8];
  assign half_data = st_addr_low[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    wb_data = st_wdata;  // alu result unless loading
    if (st_kind == lane_ops_pkg::kind_load) begin
      case (st_lsu_op)
        lane_ops_pkg::op_lb:  wb_data = {{24{byte_data[7]}}, byte_data};
        lane_ops_pkg::op_lbu: wb_data = {24'b0, byte_data};
        lane_ops_pkg::op_lh:  wb_data = {{16{half_data[15]}}, half_data};
        lane_ops_pkg::op_lhu: wb_data = {16'b0, half_data};
        default:              wb_data = rdata;  // lw
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/mem_stage_control.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_control (
  input  wire clock,
  input  wire reset,
  input  wire clear,
  input  wire lane_ops_pkg::mem_kind_t [lane_ops_pkg::NUM_LANES-1:0] lane_kind,
  input  wire lane_ops_pkg::lsu_op_t [lane_ops_pkg::NUM_LANES-1:0] lane_lsu_op,
  input  wire mem_types_pkg::addr_t [lane_ops_pkg::NUM_LANES-1:0] lane_addr,
  input  wire mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] lane_sdata,
  input  wire [lane_ops_pkg::NUM_LANES-1:0] lane_wren,
  input  wire mem_types_pkg::reg_addr_t [lane_ops_pkg::NUM_LANES-1:0] lane_waddr,
  input  wire mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] lane_wdata,
  input  wire [lane_ops_pkg::NUM_LANES-1:0] lane_cwren,
  input  wire mem_types_pkg::csr_addr_t [lane_ops_pkg::NUM_LANES-1:0] lane_caddr,
  input  wire mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] lane_cdata,
  input  wire [lane_ops_pkg::NUM_LANES-1:0] lane_exception,
  input  wire mem_types_pkg::cause_t [lane_ops_pkg::NUM_LANES-1:0] lane_ecause,
  input  wire mem_types_pkg::addr_t [lane_ops_pkg::NUM_LANES-1:0] lane_pc,
  input  wire mem_ready,
  output logic mem_valid,
  output logic mem_fence,
  output mem_types_pkg::addr_t mem_addr,
  output mem_types_pkg::word_t mem_wdata,
  output mem_types_pkg::strb_t mem_wstrb,
  output logic stall,
  output lane_ops_pkg::mem_kind_t [lane_ops_pkg::NUM_LANES-1:0] st_kind,
  output lane_ops_pkg::lsu_op_t [lane_ops_pkg::NUM_LANES-1:0] st_lsu_op,
  output mem_types_pkg::addr_t [lane_ops_pkg::NUM_LANES-1:0] st_addr,
  output logic [lane_ops_pkg::NUM_LANES-1:0] st_wren,
  output mem_types_pkg::reg_addr_t [lane_ops_pkg::NUM_LANES-1:0] st_waddr,
  output mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] st_wdata,
  output logic [lane_ops_pkg::NUM_LANES-1:0] st_cwren,
  output mem_types_pkg::csr_addr_t [lane_ops_pkg::NUM_LANES-1:0] st_caddr,
  output mem_types_pkg::word_t [lane_ops_pkg::NUM_LANES-1:0] st_cdata,
  output logic [lane_ops_pkg::NUM_LANES-1:0] st_exception,
  output mem_types_pkg::cause_t [lane_ops_pkg::NUM_LANES-1:0] st_ecause,
  output mem_types_pkg::addr_t [lane_ops_pkg::NUM_LANES-1:0] st_pc
);

  logic                    sel;         // 1 when lane 0 has no access
  lane_ops_pkg::mem_kind_t req_kind;
  lane_ops_pkg::lsu_op_t   req_op;
  mem_types_pkg::addr_t    req_addr;
  lane_ops_pkg::mem_kind_t [lane_ops_pkg::NUM_LANES-1:0] kind_q;
  logic                    busy;        // registered pair owns the port
  logic                    fence_kill;

  // ======================================
  // dtim request
  // ======================================

  assign sel       = (lane_kind[0] == lane_ops_pkg::kind_none);
  assign req_kind  = lane_kind[sel];
  assign req_op    = lane_lsu_op[sel];
  assign req_addr  = lane_addr[sel];
  assign mem_valid = (req_kind != lane_ops_pkg::kind_none) && !clear;  // flushed pair stays off
  assign mem_fence = (req_kind == lane_ops_pkg::kind_fence);
  assign mem_addr  = req_addr;

  always_comb begin
    mem_wdata = lane_sdata[sel];
    mem_wstrb = '0;
    case (req_op)
      lane_ops_pkg::op_sb: begin
        mem_wdata = {4{lane_sdata[sel][7:0]}};
        mem_wstrb = 4'b0001 << req_addr[1:0];
      end
      lane_ops_pkg::op_sh: begin
        mem_wdata = {2{lane_sdata[sel][15:0]}};
        mem_wstrb = req_addr[1] ? 4'b1100 : 4'b0011;
      end
      lane_ops_pkg::op_sw: mem_wstrb = 4'b1111;
      default: mem_wstrb = '0;
    endcase
    if (req_kind != lane_ops_pkg::kind_store) begin
      mem_wstrb = '0;  // loads and fences write nothing
    end
  end

  // ======================================
  // stall and stage register
  // ======================================

  always_comb begin
    busy = 1'b0;
    for (int l = 0; l < lane_ops_pkg::NUM_LANES; l++) begin
      busy = busy | (kind_q[l] != lane_ops_pkg::kind_none);
    end
  end

  assign stall      = busy && !mem_ready && !clear;
  assign fence_kill = (lane_kind[0] == lane_ops_pkg::kind_fence);

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      for (int l = 0; l < lane_ops_pkg::NUM_LANES; l++) begin
        kind_q[l] <= lane_ops_pkg::kind_none;
      end
      st_wren      <= '0;
      st_cwren     <= '0;
      st_exception <= '0;
    end else if (!stall) begin
      kind_q       <= lane_kind;
      st_wren      <= lane_wren;
      st_cwren     <= lane_cwren;
      st_exception <= lane_exception;
      if (fence_kill) begin
        kind_q[1]       <= lane_ops_pkg::kind_none;  // lane 1 becomes a bubble
        st_wren[1]      <= 1'b0;
        st_cwren[1]     <= 1'b0;
        st_exception[1] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      st_lsu_op <= lane_lsu_op;
      st_addr   <= lane_addr;
      st_waddr  <= lane_waddr;
      st_wdata  <= lane_wdata;
      st_caddr  <= lane_caddr;
      st_cdata  <= lane_cdata;
      st_ecause <= lane_ecause;
      st_pc     <= lane_pc;
    end
  end

  // load units see no access while the port is busy
  always_comb begin
    for (int l = 0; l < lane_ops_pkg::NUM_LANES; l++) begin
      st_kind[l] = stall ? lane_ops_pkg::kind_none : kind_q[l];
    end
  end

endmodule

`default_nettype wire

//--- hw/lane_ops_pkg.sv
`default_nettype none

package lane_ops_pkg;

  localparam int NUM_LANES = 2;  // dual issue

  // ======================================
  // operation encodings
  // ======================================

  typedef enum logic [1:0] {
    kind_none  = 2'd0,
    kind_load  = 2'd1,
    kind_store = 2'd2,
    kind_fence = 2'd3
  } mem_kind_t;

  typedef enum logic [2:0] {
    op_lb  = 3'd0,
    op_lbu = 3'd1,
    op_lh  = 3'd2,
    op_lhu = 3'd3,
    op_lw  = 3'd4,
    op_sb  = 3'd5,
    op_sh  = 3'd6,
    op_sw  = 3'd7
  } lsu_op_t;

  typedef enum logic [1:0] {
    dtim_idle    = 2'd0,
    dtim_wait    = 2'd1,  // slow region only
    dtim_respond = 2'd2
  } dtim_state_t;

endpackage

`default_nettype wire

//--- hw/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

  // ======================================
  // data path widths
  // ======================================

  typedef logic [31:0] word_t;        // integer data word
  typedef logic [31:0] addr_t;        // byte address
  typedef logic [3:0]  strb_t;        // one enable per byte lane
  typedef logic [4:0]  reg_addr_t;    // x0..x31
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0]  cause_t;       // mcause code
  typedef logic [7:0]  dtim_index_t;  // word index into the dtim

  // ======================================
  // dtim geometry
  // ======================================

  localparam int DTIM_WORDS = 256;

  // addresses with this bit set pay one wait state
  localparam int SLOW_BIT = 10;

endpackage

`default_nettype wire
